// File: hw/configure.sv
`default_nettype none

package configure;

  // ==========================================================================
  // Clock and serial timing
  // ==========================================================================

  localparam logic [31:0] CLOCK_HZ = 32'd1_843_200;
  localparam logic [31:0] BAUD_RATE = 32'd115_200;

  localparam int unsigned CLKS_PER_BIT = CLOCK_HZ / BAUD_RATE; // 16 in simulation.
  localparam int unsigned HALF_BIT = CLKS_PER_BIT / 2;          // Middle of start bit.
  localparam int unsigned COUNT_WIDTH = $clog2(CLKS_PER_BIT);

  // ==========================================================================
  // Register map
  // ==========================================================================

  localparam int unsigned STATUS_SELECT_BIT = 2; // Address bit, DATA at 0, STATUS at 4.

  localparam int unsigned TX_BUSY_BIT = 0;
  localparam int unsigned RX_FULL_BIT = 1;
  localparam int unsigned OVERRUN_BIT = 2;  // Cleared by a STATUS read.
  localparam int unsigned FRAMING_BIT = 3;  // Cleared by a STATUS read.

endpackage

`default_nettype wire

// File: hw/wires.sv
`default_nettype none

package wires;

  // ==========================================================================
  // Vector types
  // ==========================================================================

  typedef logic [31:0] word_t;   // Bus address and data.
  typedef logic [3:0] strb_t;    // Byte lanes.
  typedef logic [7:0] byte_t;    // Serial payload.
  typedef logic [configure::COUNT_WIDTH-1:0] count_t;

  // ==========================================================================
  // Processor bus
  // ==========================================================================

  typedef struct packed {
    logic valid;
    word_t addr;
    word_t wdata;
    strb_t wstrb;  // Any lane set means write.
  } bus_req_t;

  typedef struct packed {
    word_t rdata;  // Zero unless ready.
    logic ready;
  } bus_rsp_t;

  // ==========================================================================
  // Engine links
  // ==========================================================================

  // Start only while the transmitter is idle.
  typedef struct packed {
    logic start;
    byte_t data;
  } tx_cmd_t;

  // One pulse per received frame.
  typedef struct packed {
    logic done;
    byte_t data;
    logic framing_error;
  } rx_event_t;

endpackage

`default_nettype wire

// File: hw/uart_tx.sv
`default_nettype none

module uart_tx (
  input  logic            clock,
  input  logic            reset,
  input  wires::tx_cmd_t  tx_cmd,
  output logic            tx_busy,
  output logic            tx
);

  typedef enum logic [1:0] {
    idle,
    start_bit,
    data_bits,
    stop_bit
  } state_t;

  state_t        state;
  wires::count_t timer;
  logic [2:0]    bit_index;
  wires::byte_t  shift;
  logic          line;
  logic          bit_done;

  assign bit_done = (timer == wires::count_t'(configure::CLKS_PER_BIT - 1));

  // ==========================================================================
  // Frame sequencer
  // ==========================================================================

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
      timer <= '0;
      bit_index <= '0;
      line <= 1'b1;
    end else begin
      case (state)
        idle: begin
          timer <= '0;
          if (tx_cmd.start) begin
            state <= start_bit;
            line <= 1'b0;
          end
        end
        start_bit: begin
          timer <= timer + 1'b1;
          if (bit_done) begin
            timer <= '0;
            bit_index <= '0;
            state <= data_bits;
            line <= shift[0];  // LSB first.
          end
        end
        data_bits: begin
          timer <= timer + 1'b1;
          if (bit_done) begin
            timer <= '0;
            if (bit_index == 3'd7) begin
              state <= stop_bit;
              line <= 1'b1;
            end else begin
              bit_index <= bit_index + 3'd1;
              line <= shift[0];
            end
          end
        end
        stop_bit: begin
          timer <= timer + 1'b1;
          if (bit_done) begin
            timer <= '0;
            state <= idle;
          end
        end
        default: begin
          state <= idle;
          line <= 1'b1;
        end
      endcase
    end
  end

  // Payload shifts out one bit per bit period.
  always_ff @(posedge clock) begin
    if (state == idle && tx_cmd.start) begin
      shift <= tx_cmd.data;
    end else if (bit_done && (state == start_bit || state == data_bits)) begin
      shift <= {1'b0, shift[7:1]};
    end
  end

  assign tx_busy = (state != idle);
  assign tx = line;

endmodule

`default_nettype wire

// File: hw/uart_rx.sv
`default_nettype none

module uart_rx (
  input  logic              clock,
  input  logic              reset,
  input  logic              rx,
  output wires::rx_event_t  rx_event
);

  typedef enum logic [1:0] {
    idle,
    start_check,
    data_bits,
    stop_bit
  } state_t;

  state_t        state;
  logic          rx_meta;
  logic          rx_sync;
  wires::count_t timer;
  logic [2:0]    bit_index;
  wires::byte_t  shift;
  logic          done;
  logic          framing_error;
  logic          half_done;
  logic          bit_done;

  // Line is asynchronous to the clock.
  always_ff @(posedge clock) begin
    if (reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  assign half_done = (timer == wires::count_t'(configure::HALF_BIT - 1));
  assign bit_done = (timer == wires::count_t'(configure::CLKS_PER_BIT - 1));

  // ==========================================================================
  // Frame sequencer
  // ==========================================================================

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
      timer <= '0;
      bit_index <= '0;
      done <= 1'b0;
      framing_error <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        idle: begin
          timer <= '0;
          if (!rx_sync) begin
            state <= start_check;
          end
        end
        start_check: begin
          timer <= timer + 1'b1;
          if (half_done) begin
            timer <= '0;
            bit_index <= '0;
            state <= rx_sync ? idle : data_bits;  // High again means glitch.
          end
        end
        data_bits: begin
          timer <= timer + 1'b1;
          if (bit_done) begin
            timer <= '0;
            bit_index <= bit_index + 3'd1;
            if (bit_index == 3'd7) begin
              state <= stop_bit;
            end
          end
        end
        stop_bit: begin
          timer <= timer + 1'b1;
          if (bit_done) begin
            timer <= '0;
            state <= idle;
            done <= 1'b1;
            framing_error <= ~rx_sync;  // Stop bit must be high.
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // Mid-bit samples enter at the top, LSB ends at bit 0.
  always_ff @(posedge clock) begin
    if (state == data_bits && bit_done) begin
      shift <= {rx_sync, shift[7:1]};
    end
  end

  assign rx_event = '{
    done: done,
    data: shift,
    framing_error: framing_error
  };

endmodule

`default_nettype wire

// File: hw/uart.sv
`default_nettype none

module uart (
  input  logic              clock,
  input  logic              reset,
  input  wires::bus_req_t   bus_req,
  output wires::bus_rsp_t   bus_rsp,
  output wires::tx_cmd_t    tx_cmd,
  input  logic              tx_busy,
  input  wires::rx_event_t  rx_event
);

  logic         ready_q;
  logic         start_q;
  wires::byte_t tx_data;
  wires::byte_t hold;
  logic         rx_full;
  logic         overrun;
  logic         framing;
  wires::word_t rdata_q;
  wires::word_t rdata_next;
  wires::word_t status_word;

  logic pending;
  logic is_status;
  logic is_write;
  logic status_access;
  logic data_write;
  logic data_read;
  logic good_event;
  logic bad_event;
  logic tx_accept;
  logic read_held;
  logic read_direct;

  // ==========================================================================
  // Request decode
  // ==========================================================================

  assign pending = bus_req.valid & ~ready_q;  // Not yet answered.
  assign is_status = bus_req.addr[configure::STATUS_SELECT_BIT];
  assign is_write = |bus_req.wstrb;

  assign status_access = pending & is_status;
  assign data_write = pending & ~is_status & is_write;
  assign data_read = pending & ~is_status & ~is_write;

  assign good_event = rx_event.done & ~rx_event.framing_error;
  assign bad_event = rx_event.done & rx_event.framing_error;

  assign tx_accept = data_write & ~tx_busy;      // Stall while sending.
  assign read_held = data_read & rx_full;
  assign read_direct = data_read & ~rx_full & good_event;  // Byte goes straight out.

  always_comb begin
    status_word = '0;
    status_word[configure::TX_BUSY_BIT] = tx_busy;
    status_word[configure::RX_FULL_BIT] = rx_full;
    status_word[configure::OVERRUN_BIT] = overrun;
    status_word[configure::FRAMING_BIT] = framing;

    rdata_next = '0;
    if (status_access && !is_write) begin
      rdata_next = status_word;
    end else if (read_held) begin
      rdata_next = {24'b0, hold};
    end else if (read_direct) begin
      rdata_next = {24'b0, rx_event.data};
    end
  end

  // ==========================================================================
  // Control state
  // ==========================================================================

  always_ff @(posedge clock) begin
    if (reset) begin
      ready_q <= 1'b0;
      start_q <= 1'b0;
      rx_full <= 1'b0;
      overrun <= 1'b0;
      framing <= 1'b0;
    end else begin
      ready_q <= status_access | tx_accept | read_held | read_direct;
      start_q <= tx_accept;
      if (read_held) rx_full <= 1'b0;
      if (good_event && !read_direct) rx_full <= 1'b1;
      if (status_access && !is_write) begin
        overrun <= 1'b0;
        framing <= 1'b0;
      end
      if (good_event && rx_full && !read_held) overrun <= 1'b1;  // Unread byte lost.
      if (bad_event) framing <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    rdata_q <= rdata_next;
    if (tx_accept) tx_data <= bus_req.wdata[7:0];
    if (good_event && !read_direct) hold <= rx_event.data;
  end

  assign bus_rsp.ready = ready_q;
  assign bus_rsp.rdata = ready_q ? rdata_q : '0;

  assign tx_cmd.start = start_q;
  assign tx_cmd.data = tx_data;

endmodule

`default_nettype wire

// File: hw/uart_top.sv
`default_nettype none

module uart_top (
  input  logic             clock,
  input  logic             reset,
  input  wires::bus_req_t  bus_req,
  output wires::bus_rsp_t  bus_rsp,
  input  logic             rx,
  output logic             tx
);

  // ==========================================================================
  // Engine links
  // ==========================================================================

  wires::tx_cmd_t   tx_cmd;
  logic             tx_busy;
  wires::rx_event_t rx_event;

  // ==========================================================================
  // Bus front end
  // ==========================================================================

  uart uart (
    .clock    (clock),
    .reset    (reset),
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp),
    .tx_cmd   (tx_cmd),
    .tx_busy  (tx_busy),
    .rx_event (rx_event)
  );

  // ==========================================================================
  // Serial engines
  // ==========================================================================

  uart_tx uart_tx (
    .clock   (clock),
    .reset   (reset),
    .tx_cmd  (tx_cmd),
    .tx_busy (tx_busy),
    .tx      (tx)
  );

  // Receiver cannot stall, overflow shows as overrun.
  uart_rx uart_rx (
    .clock    (clock),
    .reset    (reset),
    .rx       (rx),
    .rx_event (rx_event)
  );

endmodule

`default_nettype wire

// File: bench/uart_checker.sv
`default_nettype none

module uart_checker (
  input  logic            clock,
  input  logic            reset,
  input  wires::bus_req_t bus_req,
  input  wires::bus_rsp_t bus_rsp,
  input  logic            tx,
  input  wires::word_t    expected_rdata,
  output int              errors = 0,
  output int              queued = 0
);

  timeunit 1ns;
  timeprecision 1ps;

  wires::byte_t expected_tx[$];  // Bytes acknowledged but not yet seen on tx.
  wires::word_t expected_q;
  wires::byte_t wbyte_q;
  logic         write_q;
  logic         active = 1'b0;
  logic         frame_active = 1'b0;

  // Request as the DUT saw it at the accepting edge.
  always @(posedge clock) begin
    active <= !reset;
    expected_q <= expected_rdata;
    wbyte_q <= bus_req.wdata[7:0];
    write_q <= bus_req.valid & (|bus_req.wstrb) & ~bus_req.addr[configure::STATUS_SELECT_BIT];
  end

  // ==========================================================================
  // Bus responses
  // ==========================================================================

  always @(negedge clock) begin
    if (active && bus_rsp.ready === 1'b1) begin
      if (bus_rsp.rdata !== expected_q) begin
        $display("[FAIL] bus_rsp.rdata: expected 0x%08h, actual 0x%08h",
                 expected_q, bus_rsp.rdata);
        errors++;
      end
      if (write_q) begin
        if (frame_active) begin
          $display("DATA write acknowledged while a tx frame was still on the line");
          errors++;
        end
        expected_tx.push_back(wbyte_q);
        queued = expected_tx.size();
      end
    end else if (active && bus_rsp.rdata !== '0) begin
      $display("[FAIL] bus_rsp.rdata: expected 0x00000000, actual 0x%08h", bus_rsp.rdata);
      errors++;
    end
  end

  // ==========================================================================
  // Tx line decoder
  // ==========================================================================

  always begin : tx_decoder
    wires::byte_t value;
    wires::byte_t want;
    @(posedge clock);
    if (!reset && tx === 1'b0) begin
      frame_active = 1'b1;
      repeat (configure::HALF_BIT) @(posedge clock);  // Middle of start bit.
      if (tx !== 1'b0) begin
        $display("tx start bit ended before its middle");
        errors++;
      end
      for (int i = 0; i < 8; i++) begin
        repeat (configure::CLKS_PER_BIT) @(posedge clock);
        value[i] = tx;
      end
      repeat (configure::CLKS_PER_BIT) @(posedge clock);
      if (tx !== 1'b1) begin
        $display("tx stop bit is low");
        errors++;
      end
      frame_active = 1'b0;
      if (expected_tx.size() == 0) begin
        $display("tx frame without a pending write");
        errors++;
      end else begin
        want = expected_tx.pop_front();
        queued = expected_tx.size();
        if (value !== want) begin
          $display("[FAIL] tx byte: expected 0x%02h, actual 0x%02h", want, value);
          errors++;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/uart_tb.sv
`default_nettype none

module uart_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLKS = configure::CLKS_PER_BIT;
  localparam int TX_WRITES = 6;
  localparam int RX_POLLS = 4;
  localparam int WRITES = TX_WRITES + 1;
  localparam int RX_FRAMES = RX_POLLS + 6;  // Glitch counted as a frame.
  localparam int TIMEOUT = (WRITES + RX_FRAMES) * 10 * CLKS * 3 + 1000;
  localparam wires::word_t DATA_ADDR = 32'h0;
  localparam wires::word_t STATUS_ADDR = 32'h1 << configure::STATUS_SELECT_BIT;

  logic clock = 1'b0;
  logic reset;
  logic rx;
  logic tx;
  wires::bus_req_t bus_req;
  wires::bus_rsp_t bus_rsp;
  wires::word_t expected_rdata;
  int checker_errors;
  int queued;
  int bench_errors = 0;
  int cycle = 0;
  int last_ack = 0;
  logic [31:0] seed = 32'd16;

  // Receive model: holding byte and flags.
  wires::byte_t hold = '0;
  logic rx_full = 1'b0;
  logic overrun = 1'b0;
  logic framing = 1'b0;

  uart_top UUT (.clock(clock), .reset(reset), .bus_req(bus_req), .bus_rsp(bus_rsp),
                .rx(rx), .tx(tx));

  uart_checker uart_checker (.clock(clock), .reset(reset), .bus_req(bus_req),
                             .bus_rsp(bus_rsp), .tx(tx), .expected_rdata(expected_rdata),
                             .errors(checker_errors), .queued(queued));

  always #4 clock = ~clock;

  always @(posedge clock) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT) begin
      bench_errors++;
      $display("timeout after %0d cycles", cycle);
      $display("errors: checker %0d, bench %0d", checker_errors, bench_errors);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ==========================================================================
  // Stimulus helpers
  // ==========================================================================

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_byte(output wires::byte_t value);
    seed = lcg_next(seed);
    value = seed[31:24];
  endtask

  function automatic wires::word_t status_value(input logic busy);
    wires::word_t value;
    value = '0;
    value[configure::TX_BUSY_BIT] = busy;
    value[configure::RX_FULL_BIT] = rx_full;
    value[configure::OVERRUN_BIT] = overrun;
    value[configure::FRAMING_BIT] = framing;
    return value;
  endfunction

  // Holds the request until ready, then drops valid.
  task automatic bus_access(input wires::word_t addr, input wires::word_t wdata,
                            input wires::strb_t wstrb, input wires::word_t expected);
    bus_req = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
    expected_rdata = expected;
    @(negedge clock);
    while (!bus_rsp.ready) begin
      @(negedge clock);
    end
    bus_req = '0;
  endtask

  task automatic write_data(input wires::byte_t value);
    seed = lcg_next(seed);
    bus_access(DATA_ADDR, {seed[27:4], value}, 4'b0001 << seed[17:16], '0);
    last_ack = cycle;
  endtask

  task automatic check_status(input logic busy);
    bus_access(STATUS_ADDR, '0, '0, status_value(busy));
    overrun = 1'b0;
    framing = 1'b0;
  endtask

  task automatic read_data();
    bus_access(DATA_ADDR, '0, '0, {24'b0, hold});
    rx_full = 1'b0;
  endtask

  task automatic wait_tx_idle();
    while (cycle < last_ack + 10 * CLKS + 4) begin
      @(negedge clock);
    end
  endtask

  // 8N1 frame plus one idle bit so the receiver settles.
  task automatic drive_frame(input wires::byte_t value, input logic stop);
    rx = 1'b0;
    repeat (CLKS) @(negedge clock);
    for (int i = 0; i < 8; i++) begin
      rx = value[i];
      repeat (CLKS) @(negedge clock);
    end
    rx = stop;
    repeat (CLKS) @(negedge clock);
    rx = 1'b1;
    repeat (CLKS) @(negedge clock);
  endtask

  task automatic receive_frame(input wires::byte_t value, input logic stop);
    drive_frame(value, stop);
    if (!stop) begin
      framing = 1'b1;
    end else begin
      overrun = overrun | rx_full;
      hold = value;
      rx_full = 1'b1;
    end
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================

  initial begin : stimulus
    wires::byte_t value;
    wires::byte_t second;
    reset = 1'b1;
    rx = 1'b1;
    bus_req = '0;
    expected_rdata = '0;
    repeat (3) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);

    for (int i = 0; i < TX_WRITES; i++) begin
      next_byte(value);
      write_data(value);
      if (value[0]) repeat (value[3:1]) @(negedge clock);  // Others go back to back.
    end
    wait_tx_idle();

    next_byte(value);
    write_data(value);
    repeat (4) @(negedge clock);
    check_status(1'b1);
    wait_tx_idle();

    for (int i = 0; i < RX_POLLS; i++) begin
      next_byte(value);
      receive_frame(value, 1'b1);
      check_status(1'b0);
      read_data();
      check_status(1'b0);
    end

    // Read waits on an empty buffer.
    next_byte(value);
    fork
      begin
        repeat (2 * CLKS) @(negedge clock);
        drive_frame(value, 1'b1);
      end
      bus_access(DATA_ADDR, '0, '0, {24'b0, value});
    join
    check_status(1'b0);

    next_byte(value);
    next_byte(second);
    receive_frame(value, 1'b1);
    receive_frame(second, 1'b1);
    check_status(1'b0);
    read_data();
    check_status(1'b0);

    next_byte(value);
    receive_frame(value, 1'b1);
    next_byte(second);
    receive_frame(second, 1'b0);
    bus_access(STATUS_ADDR, seed, 4'hf, '0);
    check_status(1'b0);
    read_data();
    rx = 1'b0;
    repeat (configure::HALF_BIT / 2) @(negedge clock);
    rx = 1'b1;
    repeat (2 * CLKS) @(negedge clock);
    check_status(1'b0);

    repeat (4 * CLKS) @(negedge clock);
    if (queued != 0) begin
      $display("%0d written bytes never appeared on tx", queued);
      bench_errors++;
    end
    $display("errors: checker %0d, bench %0d", checker_errors, bench_errors);
    if (checker_errors == 0 && bench_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
hw/configure.sv
hw/wires.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart.sv
hw/uart_top.sv
bench/uart_checker.sv
bench/uart_tb.sv

// File: Bender.yml
package:
  name: uart

sources:
  - hw/configure.sv
  - hw/wires.sv
  - hw/uart_tx.sv
  - hw/uart_rx.sv
  - hw/uart.sv
  - hw/uart_top.sv
  - target: test
    files:
      - bench/uart_checker.sv
      - bench/uart_tb.sv
